//--- floo_b_rob.f
verilog/floo_rob_pkg.sv
verilog/floo_rob_if.sv
verilog/floo_rob_id_demux.sv
verilog/floo_simple_rob.sv
verilog/floo_rob_rsp_arbiter.sv
verilog/floo_b_rob.sv
test/tb_floo_b_rob.sv

//--- test/tb_floo_b_rob.sv
////////////////////
// Testbench for the B response reorder unit
// Table driven AW issue, shuffled B return and in-order release checks
////////////////////

module tb_floo_b_rob import floo_rob_pkg::*; ();

  typedef struct packed {
    id_t     id;
    dest_t   dest;
    b_resp_t resp;
    b_user_t user;
  } stim_t;

  localparam int TblSize = 16;
  localparam int Timeout = 100;
  localparam logic [31:0] LfsrSeed = 32'hd86b;

  // Columns: ID, destination, B response code, B user
  localparam stim_t Stim [TblSize] = '{
    '{2'd0, 4'h3, 2'b00, 4'h1}, '{2'd1, 4'h7, 2'b01, 4'h2},
    '{2'd2, 4'h1, 2'b10, 4'h3}, '{2'd3, 4'hc, 2'b11, 4'h4},
    '{2'd2, 4'h5, 2'b00, 4'h5}, '{2'd0, 4'h9, 2'b10, 4'h6},
    '{2'd3, 4'h2, 2'b01, 4'h7}, '{2'd1, 4'he, 2'b11, 4'h8},
    '{2'd1, 4'h4, 2'b00, 4'h9}, '{2'd3, 4'h8, 2'b10, 4'ha},
    '{2'd0, 4'hb, 2'b01, 4'hb}, '{2'd2, 4'h6, 2'b11, 4'hc},
    '{2'd3, 4'hd, 2'b00, 4'hd}, '{2'd2, 4'h0, 2'b01, 4'he},
    '{2'd1, 4'ha, 2'b10, 4'hf}, '{2'd0, 4'hf, 2'b11, 4'h0}
  };

  logic     clk_i;
  logic     reset_i;
  logic     ax_valid_i;
  logic     ax_ready_o;
  id_t      ax_id_i;
  dest_t    ax_dest_i;
  logic     ax_valid_o;
  logic     ax_ready_i;
  id_t      ax_id_o;
  dest_t    ax_dest_o;
  rob_idx_t ax_rob_idx_o;
  logic     rsp_valid_i;
  id_t      rsp_id_i;
  rob_idx_t rsp_rob_idx_i;
  b_resp_t  rsp_resp_i;
  b_user_t  rsp_user_i;
  logic     rsp_valid_o;
  logic     rsp_ready_i;
  id_t      rsp_id_o;
  b_resp_t  rsp_resp_o;
  b_user_t  rsp_user_o;

  // Reference model, expected B per ID in issue order
  b_resp_t     exp_resp [NumIds][$];
  b_user_t     exp_user [NumIds][$];
  int          slot_cnt [NumIds] = '{default: 0};
  // Responses issued but not yet returned by the network
  id_t         pend_id [$];
  rob_idx_t    pend_idx [$];
  b_resp_t     pend_resp [$];
  b_user_t     pend_user [$];
  id_t         seen_ids [$];
  logic [31:0] lfsr_q = LfsrSeed;

  floo_b_rob u_floo_b_rob (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  ////////////////////
  // Helpers
  ////////////////////

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) abort_run($sformatf("Error %s expected 0x%h actual 0x%h", name, exp, act));
  endtask

  task automatic check_id(input string name, input id_t exp, input id_t act);
    if (act !== exp) abort_run($sformatf("Error %s expected 0x%h actual 0x%h", name, exp, act));
  endtask

  task automatic check_dest(input string name, input dest_t exp, input dest_t act);
    if (act !== exp) abort_run($sformatf("Error %s expected 0x%h actual 0x%h", name, exp, act));
  endtask

  task automatic check_idx(input string name, input rob_idx_t exp, input rob_idx_t act);
    if (act !== exp) abort_run($sformatf("Error %s expected 0x%h actual 0x%h", name, exp, act));
  endtask

  task automatic check_resp(input string name, input b_resp_t exp, input b_resp_t act);
    if (act !== exp) abort_run($sformatf("Error %s expected 0x%h actual 0x%h", name, exp, act));
  endtask

  task automatic check_user(input string name, input b_user_t exp, input b_user_t act);
    if (act !== exp) abort_run($sformatf("Error %s expected 0x%h actual 0x%h", name, exp, act));
  endtask

  // Taps 32, 22, 2, 1
  function automatic int rand_bits(input int n);
    int   v;
    logic fb;
    v = 0;
    for (int b = 0; b < n; b++) begin
      fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      v = (v << 1) | int'(fb);
    end
    return v;
  endfunction

  // Offer one AW and wait until the DUT passes it on
  task automatic issue(input id_t id, input dest_t dest, input b_resp_t resp,
                       input b_user_t user);
    int waited;
    @(posedge clk_i);
    ax_valid_i <= 1'b1;
    ax_id_i <= id;
    ax_dest_i <= dest;
    @(negedge clk_i);
    waited = 0;
    while (!ax_valid_o) begin
      if (waited == Timeout) abort_run($sformatf("AW for ID %0d was never accepted", id));
      waited++;
      @(negedge clk_i);
    end
    check_flag("ax_ready_o", 1'b1, ax_ready_o);
    check_id("ax_id_o", id, ax_id_o);
    check_dest("ax_dest_o", dest, ax_dest_o);
    check_idx("ax_rob_idx_o", rob_idx_t'(slot_cnt[id] % RobDepth), ax_rob_idx_o);
    exp_resp[id].push_back(resp);
    exp_user[id].push_back(user);
    pend_id.push_back(id);
    pend_idx.push_back(rob_idx_t'(slot_cnt[id] % RobDepth));
    pend_resp.push_back(resp);
    pend_user.push_back(user);
    slot_cnt[id]++;
    @(posedge clk_i);
    ax_valid_i <= 1'b0;
  endtask

  task automatic send_rsp(input int k);
    @(posedge clk_i);
    rsp_valid_i <= 1'b1;
    rsp_id_i <= pend_id[k];
    rsp_rob_idx_i <= pend_idx[k];
    rsp_resp_i <= pend_resp[k];
    rsp_user_i <= pend_user[k];
    pend_id.delete(k);
    pend_idx.delete(k);
    pend_resp.delete(k);
    pend_user.delete(k);
  endtask

  // Network returns everything outstanding in shuffled order
  task automatic return_shuffled();
    while (pend_id.size() > 0) begin
      send_rsp(rand_bits(8) % pend_id.size());
    end
    @(posedge clk_i);
    rsp_valid_i <= 1'b0;
  endtask

  task automatic wait_drained();
    int waited;
    int left;
    waited = 0;
    left = 1;
    while (left > 0) begin
      @(posedge clk_i);
      left = 0;
      for (int i = 0; i < NumIds; i++) left += exp_resp[i].size();
      if (left > 0 && waited == Timeout) abort_run("B responses still outstanding at timeout");
      waited++;
    end
  endtask

  // B output monitor, sampled mid-cycle where the handshake is settled
  initial begin
    forever begin
      @(negedge clk_i);
      if (!reset_i && rsp_valid_o && rsp_ready_i) begin
        if (exp_resp[rsp_id_o].size() == 0) begin
          abort_run($sformatf("B response on ID %0d with nothing outstanding", rsp_id_o));
        end else begin
          check_resp("rsp_resp_o", exp_resp[rsp_id_o][0], rsp_resp_o);
          check_user("rsp_user_o", exp_user[rsp_id_o][0], rsp_user_o);
          void'(exp_resp[rsp_id_o].pop_front());
          void'(exp_user[rsp_id_o].pop_front());
          seen_ids.push_back(rsp_id_o);
        end
      end
    end
  end

  ////////////////////
  // Test sequence
  ////////////////////

  initial begin
    id_t     held_id;
    b_resp_t held_resp;
    b_user_t held_user;
    id_t     want;
    int      left [NumIds];
    int      total;
    int      head;
    logic    found;

    reset_i = 1'b1;
    ax_valid_i = 1'b0;
    ax_ready_i = 1'b0;
    ax_id_i = '0;
    ax_dest_i = '0;
    rsp_valid_i = 1'b0;
    rsp_id_i = '0;
    rsp_rob_idx_i = '0;
    rsp_resp_i = '0;
    rsp_user_i = '0;
    rsp_ready_i = 1'b0;
    repeat (2) @(posedge clk_i);
    reset_i <= 1'b0;

    @(negedge clk_i);
    check_flag("ax_valid_o", 1'b0, ax_valid_o);
    check_flag("ax_ready_o", 1'b0, ax_ready_o);
    check_flag("rsp_valid_o", 1'b0, rsp_valid_o);
    @(posedge clk_i);
    ax_ready_i <= 1'b1;
    rsp_ready_i <= 1'b1;

    // Allocation and in-order release across all IDs
    for (int k = 0; k < TblSize; k++) issue(Stim[k].id, Stim[k].dest, Stim[k].resp, Stim[k].user);
    return_shuffled();
    wait_drained();

    // Fill lane 1, a ninth request must stall while lane 2 still passes
    for (int k = 0; k < RobDepth; k++) issue(2'd1, Stim[k].dest, Stim[k].resp, Stim[k].user);
    @(posedge clk_i);
    ax_valid_i <= 1'b1;
    ax_id_i <= 2'd1;
    repeat (3) begin
      @(negedge clk_i);
      check_flag("ax_valid_o", 1'b0, ax_valid_o);
      check_flag("ax_ready_o", 1'b0, ax_ready_o);
    end
    issue(2'd2, Stim[8].dest, Stim[8].resp, Stim[8].user);
    head = 0;
    while (pend_id[head] != 2'd1) head++;
    send_rsp(head);
    @(posedge clk_i);
    rsp_valid_i <= 1'b0;
    issue(2'd1, Stim[9].dest, Stim[9].resp, Stim[9].user);

    // Load every lane while the B port is stalled
    @(posedge clk_i);
    rsp_ready_i <= 1'b0;
    for (int k = 0; k < 8; k++) begin
      if (Stim[k].id != 2'd1) issue(Stim[k].id, Stim[k].dest, Stim[k].resp, Stim[k].user);
    end
    return_shuffled();
    @(negedge clk_i);
    total = 0;
    while (!rsp_valid_o) begin
      if (total == Timeout) abort_run("B output never became valid under back-pressure");
      total++;
      @(negedge clk_i);
    end
    held_id = rsp_id_o;
    held_resp = rsp_resp_o;
    held_user = rsp_user_o;
    check_resp("rsp_resp_o", exp_resp[held_id][0], held_resp);
    check_user("rsp_user_o", exp_user[held_id][0], held_user);
    repeat (5) begin
      @(negedge clk_i);
      check_flag("rsp_valid_o", 1'b1, rsp_valid_o);
      check_id("rsp_id_o", held_id, rsp_id_o);
      check_resp("rsp_resp_o", held_resp, rsp_resp_o);
      check_user("rsp_user_o", held_user, rsp_user_o);
    end

    // Release and follow the rotation, the held lane goes first
    @(posedge clk_i);
    for (int i = 0; i < NumIds; i++) begin
      left[i] = exp_resp[i].size();
    end
    seen_ids.delete();
    rsp_ready_i <= 1'b1;
    wait_drained();
    want = held_id;
    foreach (seen_ids[k]) begin
      check_id("rsp_id_o", want, seen_ids[k]);
      left[seen_ids[k]]--;
      found = 1'b0;
      for (int j = 1; j <= NumIds; j++) begin
        if (!found && left[(int'(seen_ids[k]) + j) % NumIds] > 0) begin
          want = id_t'((int'(seen_ids[k]) + j) % NumIds);
          found = 1'b1;
        end
      end
    end

    @(posedge clk_i);
    $display("sim passed");
    $finish;
  end

endmodule

//--- verilog/floo_b_rob.sv
////////////////////
// Write response reorder unit
// Per-ID reorder lanes between AW issue and the merged B port
////////////////////

module floo_b_rob import floo_rob_pkg::*; (
  input  logic     clk_i,
  input  logic     reset_i,
  // AW in
  input  logic     ax_valid_i,
  output logic     ax_ready_o,
  input  id_t      ax_id_i,
  input  dest_t    ax_dest_i,
  // AW out
  output logic     ax_valid_o,
  input  logic     ax_ready_i,
  output id_t      ax_id_o,
  output dest_t    ax_dest_o,
  output rob_idx_t ax_rob_idx_o,
  // B in
  input  logic     rsp_valid_i,
  input  id_t      rsp_id_i,
  input  rob_idx_t rsp_rob_idx_i,
  input  b_resp_t  rsp_resp_i,
  input  b_user_t  rsp_user_i,
  // B out
  output logic     rsp_valid_o,
  input  logic     rsp_ready_i,
  output id_t      rsp_id_o,
  output b_resp_t  rsp_resp_o,
  output b_user_t  rsp_user_o
);

  floo_rob_lane_if  lane_if  [NumIds] ();
  floo_rob_drain_if drain_if [NumIds] ();

  floo_rob_id_demux u_demux (
    .clk_i         ( clk_i         ),
    .reset_i       ( reset_i       ),
    .ax_valid_i    ( ax_valid_i    ),
    .ax_id_i       ( ax_id_i       ),
    .ax_dest_i     ( ax_dest_i     ),
    .ax_ready_o    ( ax_ready_o    ),
    .ax_ready_i    ( ax_ready_i    ),
    .ax_valid_o    ( ax_valid_o    ),
    .ax_id_o       ( ax_id_o       ),
    .ax_dest_o     ( ax_dest_o     ),
    .ax_rob_idx_o  ( ax_rob_idx_o  ),
    .rsp_valid_i   ( rsp_valid_i   ),
    .rsp_id_i      ( rsp_id_i      ),
    .rsp_rob_idx_i ( rsp_rob_idx_i ),
    .rsp_resp_i    ( rsp_resp_i    ),
    .rsp_user_i    ( rsp_user_i    ),
    .lane_o        ( lane_if       )
  );

  // One reorder lane per AXI ID
  for (genvar i = 0; i < NumIds; i++) begin : gen_rob
    floo_simple_rob u_rob (
      .clk_i   ( clk_i       ),
      .reset_i ( reset_i     ),
      .lane_i  ( lane_if[i]  ),
      .drain_o ( drain_if[i] )
    );
  end

  floo_rob_rsp_arbiter u_arbiter (
    .clk_i       ( clk_i       ),
    .reset_i     ( reset_i     ),
    .lane_i      ( drain_if    ),
    .rsp_valid_o ( rsp_valid_o ),
    .rsp_ready_i ( rsp_ready_i ),
    .rsp_id_o    ( rsp_id_o    ),
    .rsp_resp_o  ( rsp_resp_o  ),
    .rsp_user_o  ( rsp_user_o  )
  );

endmodule

//--- verilog/floo_rob_rsp_arbiter.sv
////////////////////
// Round-robin B response merge
// Picks one lane head per cycle and holds it under back-pressure
////////////////////

module floo_rob_rsp_arbiter import floo_rob_pkg::*; (
  input  logic                 clk_i,
  input  logic                 reset_i,
  floo_rob_drain_if.arb        lane_i [NumIds],
  output logic                 rsp_valid_o,
  input  logic                 rsp_ready_i,
  output id_t                  rsp_id_o,
  output b_resp_t              rsp_resp_o,
  output b_user_t              rsp_user_o
);

  logic [NumIds-1:0] head_valid;
  b_resp_t           head_resp [NumIds];
  b_user_t           head_user [NumIds];
  logic [NumIds-1:0] pop;
  id_t               last_q;
  logic              hold_q;
  id_t               hold_id_q;
  id_t               grant;
  logic              handshake;

  for (genvar i = 0; i < NumIds; i++) begin : gen_lane
    assign head_valid[i] = lane_i[i].head_valid;
    assign head_resp[i] = lane_i[i].head_resp;
    assign head_user[i] = lane_i[i].head_user;
    assign pop[i] = handshake && (grant == id_t'(i));
    assign lane_i[i].head_pop = pop[i];
  end

  ////////////////////
  // Grant search
  ////////////////////

  // Start after the last popped lane, the last lane itself comes last.
  // Walking backwards lets the nearest candidate win.
  always_comb begin
    id_t cand;
    cand = last_q;
    grant = hold_id_q;
    if (!hold_q) begin
      grant = last_q;
      for (int k = NumIds; k >= 1; k--) begin
        cand = id_t'((int'(last_q) + k) % NumIds);
        if (head_valid[cand]) begin
          grant = cand;
        end
      end
    end
  end

  assign rsp_valid_o = head_valid[grant];
  assign rsp_id_o = grant;
  assign rsp_resp_o = head_resp[grant];
  assign rsp_user_o = head_user[grant];
  assign handshake = rsp_valid_o && rsp_ready_i;

  // Lane 0 is searched first out of reset
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      last_q <= id_t'(NumIds - 1);
      hold_q <= 1'b0;
      hold_id_q <= '0;
    end else begin
      // Lock the grant while the output waits on ready
      hold_q <= rsp_valid_o && !rsp_ready_i;
      hold_id_q <= grant;
      if (handshake) begin
        last_q <= grant;
      end
    end
  end

  assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot0(pop))
    else $error("More than one lane popped");

  // Stalled response keeps its lane and payload
  assert property (@(posedge clk_i) disable iff (reset_i)
    rsp_valid_o && !rsp_ready_i |=>
      rsp_valid_o && $stable({rsp_id_o, rsp_resp_o, rsp_user_o}))
    else $error("B output changed under back-pressure");

endmodule

//--- verilog/floo_simple_rob.sv
////////////////////
// Simple per-ID reorder buffer
// Slots are reserved in issue order, filled in any order
// and released strictly from the head
////////////////////

module floo_simple_rob import floo_rob_pkg::*; (
  input  logic            clk_i,
  input  logic            reset_i,
  floo_rob_lane_if.rob    lane_i,
  floo_rob_drain_if.rob   drain_o
);

  rob_idx_t            wr_ptr_q, wr_ptr_d;
  rob_idx_t            rd_ptr_q, rd_ptr_d;
  rob_cnt_t            count_q, count_d;
  logic [RobDepth-1:0] slot_valid_q, slot_valid_d;
  b_resp_t             slot_resp_q [RobDepth];
  b_user_t             slot_user_q [RobDepth];
  logic                alloc;
  logic                pop;

  // Circular increment, also correct for depths that are not a power of two
  function automatic rob_idx_t next_idx(rob_idx_t idx);
    if (idx == rob_idx_t'(RobDepth - 1)) begin
      return '0;
    end
    return idx + 1'b1;
  endfunction

  ////////////////////
  // Allocation
  ////////////////////

  assign lane_i.alloc_ready = (count_q < rob_cnt_t'(RobDepth));
  assign lane_i.alloc_idx = wr_ptr_q;

  assign alloc = lane_i.alloc_valid && lane_i.alloc_ready;
  assign pop = drain_o.head_pop;

  ////////////////////
  // Head of buffer
  ////////////////////

  assign drain_o.head_valid = slot_valid_q[rd_ptr_q];
  assign drain_o.head_resp = slot_resp_q[rd_ptr_q];
  assign drain_o.head_user = slot_user_q[rd_ptr_q];

  always_comb begin
    wr_ptr_d = wr_ptr_q;
    rd_ptr_d = rd_ptr_q;
    slot_valid_d = slot_valid_q;

    if (alloc) begin
      wr_ptr_d = next_idx(wr_ptr_q);
    end

    // Release first, a fill can never hit the head while it is still valid
    if (pop) begin
      slot_valid_d[rd_ptr_q] = 1'b0;
      rd_ptr_d = next_idx(rd_ptr_q);
    end
    if (lane_i.fill_valid) begin
      slot_valid_d[lane_i.fill_idx] = 1'b1;
    end

    // Simultaneous alloc and pop leaves occupancy unchanged
    case ({alloc, pop})
      2'b10:   count_d = count_q + 1'b1;
      2'b01:   count_d = count_q - 1'b1;
      default: count_d = count_q;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q <= '0;
      slot_valid_q <= '0;
    end else begin
      wr_ptr_q <= wr_ptr_d;
      rd_ptr_q <= rd_ptr_d;
      count_q <= count_d;
      slot_valid_q <= slot_valid_d;
    end
  end

  // Response metadata, qualified by the slot valid flags
  always_ff @(posedge clk_i) begin
    if (lane_i.fill_valid) begin
      slot_resp_q[lane_i.fill_idx] <= lane_i.fill_resp;
      slot_user_q[lane_i.fill_idx] <= lane_i.fill_user;
    end
  end

  ////////////////////
  // Checks
  ////////////////////

  // Network returned a response for a slot that already holds one
  assert property (@(posedge clk_i) disable iff (reset_i)
    lane_i.fill_valid |-> !slot_valid_q[lane_i.fill_idx])
    else $error("Fill into a slot that is already valid");

  assert property (@(posedge clk_i) disable iff (reset_i)
    count_q <= rob_cnt_t'(RobDepth))
    else $error("Occupancy above buffer depth");

  // Arbiter must only drain a ready head
  assert property (@(posedge clk_i) disable iff (reset_i)
    drain_o.head_pop |-> drain_o.head_valid)
    else $error("Pop of an empty head");

endmodule

//--- verilog/floo_rob_id_demux.sv
////////////////////
// ID demultiplexer
// Routes AW allocation and returning B fills to the lane of their ID
// and tags the outgoing AW with the reserved slot
////////////////////

module floo_rob_id_demux import floo_rob_pkg::*; (
  input  logic                  clk_i,
  input  logic                  reset_i,
  // AW from the endpoint
  input  logic                  ax_valid_i,
  input  id_t                   ax_id_i,
  input  dest_t                 ax_dest_i,
  output logic                  ax_ready_o,
  // AW toward the network
  input  logic                  ax_ready_i,
  output logic                  ax_valid_o,
  output id_t                   ax_id_o,
  output dest_t                 ax_dest_o,
  output rob_idx_t              ax_rob_idx_o,
  // B from the network
  input  logic                  rsp_valid_i,
  input  id_t                   rsp_id_i,
  input  rob_idx_t              rsp_rob_idx_i,
  input  b_resp_t               rsp_resp_i,
  input  b_user_t               rsp_user_i,
  // One link per lane
  floo_rob_lane_if.demux        lane_o [NumIds]
);

  logic [NumIds-1:0] alloc_valid;
  logic [NumIds-1:0] lane_free;
  rob_idx_t          lane_idx [NumIds];
  logic              sel_free;

  ////////////////////
  // Per lane decode
  ////////////////////

  for (genvar i = 0; i < NumIds; i++) begin : gen_lane
    // Allocation only fires when the network side takes the request
    assign alloc_valid[i] = ax_valid_i && ax_ready_i && (ax_id_i == id_t'(i));
    assign lane_o[i].alloc_valid = alloc_valid[i];

    // Interface arrays cannot take a dynamic index, so flatten first
    assign lane_free[i] = lane_o[i].alloc_ready;
    assign lane_idx[i] = lane_o[i].alloc_idx;

    assign lane_o[i].fill_valid = rsp_valid_i && (rsp_id_i == id_t'(i));
    assign lane_o[i].fill_idx = rsp_rob_idx_i;
    assign lane_o[i].fill_resp = rsp_resp_i;
    assign lane_o[i].fill_user = rsp_user_i;
  end

  ////////////////////
  // AW handshake
  ////////////////////

  // A full lane holds the request upstream
  assign sel_free = lane_free[ax_id_i];

  assign ax_valid_o = ax_valid_i && sel_free;
  assign ax_ready_o = ax_ready_i && sel_free;
  assign ax_id_o = ax_id_i;
  assign ax_dest_o = ax_dest_i;
  assign ax_rob_idx_o = lane_idx[ax_id_i];

  // Only one lane may reserve a slot per cycle
  assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot0(alloc_valid))
    else $error("Allocation offered to more than one lane");

endmodule

//--- verilog/floo_rob_if.sv
////////////////////
// Reorder lane links
// Demux to lane (allocation and fill) and lane to arbiter (head drain)
////////////////////

// Allocation handshake plus the fill strobe for a returning B response
interface floo_rob_lane_if import floo_rob_pkg::*; ();

  logic     alloc_valid;
  logic     alloc_ready;
  rob_idx_t alloc_idx;

  // No ready on fill, the slot was reserved at issue
  logic     fill_valid;
  rob_idx_t fill_idx;
  b_resp_t  fill_resp;
  b_user_t  fill_user;

  modport demux (
    output alloc_valid,
    input  alloc_ready,
    input  alloc_idx,
    output fill_valid,
    output fill_idx,
    output fill_resp,
    output fill_user
  );

  modport rob (
    input  alloc_valid,
    output alloc_ready,
    output alloc_idx,
    input  fill_valid,
    input  fill_idx,
    input  fill_resp,
    input  fill_user
  );

endinterface

// Head of one lane as seen by the output arbiter
interface floo_rob_drain_if import floo_rob_pkg::*; ();

  logic    head_valid;
  b_resp_t head_resp;
  b_user_t head_user;
  logic    head_pop;

  modport rob (
    output head_valid,
    output head_resp,
    output head_user,
    input  head_pop
  );

  modport arb (
    input  head_valid,
    input  head_resp,
    input  head_user,
    output head_pop
  );

endinterface

//--- verilog/floo_rob_pkg.sv
////////////////////
// B response reorder unit shared definitions
// Widths, buffer depth and the vector types used on every port
////////////////////

package floo_rob_pkg;

  ////////////////////
  // Sizing
  ////////////////////

  // One lane per AXI write ID
  localparam int unsigned NumIds = 4;
  // Slots per lane
  localparam int unsigned RobDepth = 8;

  localparam int unsigned IdWidth = $clog2(NumIds);
  localparam int unsigned IdxWidth = $clog2(RobDepth);
  // Occupancy must be able to hold RobDepth itself
  localparam int unsigned CntWidth = $clog2(RobDepth + 1);
  localparam int unsigned DestWidth = 4;
  localparam int unsigned RespWidth = 2;
  localparam int unsigned UserWidth = 4;

  ////////////////////
  // Types
  ////////////////////

  typedef logic [IdWidth-1:0] id_t;
  typedef logic [DestWidth-1:0] dest_t;
  typedef logic [IdxWidth-1:0] rob_idx_t;
  typedef logic [CntWidth-1:0] rob_cnt_t;
  typedef logic [RespWidth-1:0] b_resp_t;
  typedef logic [UserWidth-1:0] b_user_t;

endpackage
